// ==== include/wb_mem_config.svh ====
`ifndef WB_MEM_CONFIG_SVH
`define WB_MEM_CONFIG_SVH

// Word address width of the RAM, 2**WB_ADDR_W words
`define WB_ADDR_W 8

// Width of the command transfer count
`define WB_LEN_W 8

// Copy buffer depth, power of two
`define WB_FIFO_DEPTH 4

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status is the run result
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module wb_copy_tb -f wb_copy_top.f -o wb_copy_sim \
  && ./obj_dir/wb_copy_sim \
  || { echo "Simulation build or run failed"; exit 1; }

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free running clock and synchronous reset for the testbench
module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;                          // Held over the first edges
    repeat (RST_CYCLES) @(posedge clk_o);
    #5 rst_o = 1'b0;                       // Same offset as the stimulus
  end

endmodule

`default_nettype wire

// ==== verif/wb_copy_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wb_mem_config.svh"

module wb_copy_tb;

  import wb_mem_pkg::*;

  localparam int AW     = `WB_ADDR_W;
  localparam int LW     = `WB_LEN_W;
  localparam int WORDS  = 1 << AW;
  localparam int MAXLEN = (1 << LW) - 1;
  localparam int RUN0   = (4 * `WB_FIFO_DEPTH + 24 < MAXLEN) ? 4 * `WB_FIFO_DEPTH + 24 : MAXLEN;
  localparam int RUNLEN = (RUN0 < WORDS / 2) ? RUN0 : WORDS / 2;  // Longest random run

  logic clk;
  logic rst;
  logic cmd_valid_i;
  logic cmd_ready_o;
  logic rsp_valid_o;
  logic rsp_ready_i;
  cmd_t cmd_i;
  rsp_t rsp_o;

  logic [31:0] shadow [WORDS];  // Expected RAM image
  rsp_t        exp_q [$];       // Expected results, oldest first
  int          issued  = 0;     // Commands taken by the DUT
  int          checked = 0;
  int          pending = 0;     // Accepted, result not yet taken
  int          bp_pct  = 100;   // Chance of rsp_ready_i per cycle, percent

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) clk_gen_i (.clk_o(clk), .rst_o(rst));

  wb_copy_top wb_copy_top_i (
    .clk, .rst, .cmd_valid_i, .cmd_i, .cmd_ready_o, .rsp_valid_o, .rsp_o, .rsp_ready_i
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped on first error");
  endtask

  // Applies one command to the shadow image and returns its result
  function automatic rsp_t ref_exec(input cmd_t c);
    rsp_t          r;
    logic [31:0]   words [$];   // Source run read before any write
    logic [AW-1:0] a;
    r.op    = c.op;
    r.value = 32'd0;
    for (int i = 0; i < int'(c.len); i++) begin
      a = c.src_addr + AW'(i);  // Wraps with the RAM
      words.push_back(shadow[a]);
      if (c.op == OP_SUM) r.value = r.value + shadow[a];
    end
    for (int i = 0; i < int'(c.len); i++) begin
      a = c.dst_addr + AW'(i);
      for (int b = 0; b < 4; b++) begin
        if (c.op == OP_COPY) shadow[a][8*b +: 8] = words[i][8*b +: 8];
        else if (c.op == OP_FILL && c.sel[b]) shadow[a][8*b +: 8] = c.pattern[8*b +: 8];
      end
    end
    return r;
  endfunction

  // Offers one command and holds it until the DUT takes it
  task automatic issue_cmd(input wb_op_e op, input int src, input int dst, input int len,
                           input logic [31:0] pat, input logic [3:0] sel);
    cmd_t c;
    c.op        = op;
    c.src_addr  = AW'(src);  // Modulo the RAM size
    c.dst_addr  = AW'(dst);
    c.len       = LW'(len);
    c.pattern   = pat;
    c.sel       = sel;
    cmd_i       = c;
    cmd_valid_i = 1'b1;
    @(negedge clk);
    while (!cmd_ready_o) @(negedge clk);
    exp_q.push_back(ref_exec(c));  // Transfers at the coming edge
    issued++;
    @(posedge clk);
    #5;
    cmd_valid_i = 1'b0;
  endtask

  // Result sink with random back-pressure
  initial begin
    wait (!rst);
    forever begin
      @(posedge clk);
      #5;
      rsp_ready_i = ($urandom_range(0, 99) < bp_pct);
    end
  end

  // Compare process, samples both ports mid-cycle
  initial begin : compare_results
    rsp_t want;
    forever begin
      @(negedge clk);
      if (!rst && rsp_valid_o && rsp_ready_i) begin
        assert (exp_q.size() != 0) else abort_run("Result returned with no command outstanding");
        want = exp_q.pop_front();
        assert (rsp_o.op === want.op)
          else abort_run($sformatf("FAILED rsp_o.op exp %h got %h", want.op, rsp_o.op));
        assert (rsp_o.value === want.value)
          else abort_run($sformatf("FAILED rsp_o.value exp %h got %h", want.value, rsp_o.value));
        pending--;
        checked++;
      end
      if (!rst && cmd_valid_i && cmd_ready_o) begin
        assert (pending == 0) else abort_run("Command accepted while a result was pending");
        pending++;
      end
    end
  end

  // Watchdog, 5000 cycles for every command issued so far
  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 5000 * (issued + 1))
        abort_run($sformatf("Timeout after %0d cycles, %0d commands issued", cycles, issued));
    end
  end

  initial begin
    wb_op_e op;
    int     len;
    int     src;
    int     dst;
    int     cyc;
    void'($urandom(52));
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    rsp_ready_i = 1'b0;
    wait (!rst);
    @(negedge clk);
    assert (rsp_valid_o === 1'b0)
      else abort_run($sformatf("FAILED rsp_valid_o exp %h got %h", 1'b0, rsp_valid_o));
    cyc = 0;
    while (cmd_ready_o !== 1'b1 && cyc < 2) begin
      @(negedge clk);
      cyc++;
    end
    assert (cmd_ready_o === 1'b1) else abort_run("cmd_ready_o did not rise within two cycles");
    @(posedge clk);
    #5;
    // Whole RAM to zero, then sums over plain and wrapping ranges
    for (int a = 0; a < WORDS; a += MAXLEN)
      issue_cmd(OP_FILL, 0, a, (WORDS - a < MAXLEN) ? WORDS - a : MAXLEN, 32'd0, 4'hF);
    issue_cmd(OP_SUM, 3, 0, MAXLEN, 32'd0, 4'hF);
    issue_cmd(OP_SUM, WORDS - 7, 0, 20, 32'd0, 4'hF);
    // Every nonzero byte mask
    for (int m = 1; m < 16; m++) begin
      src = int'($urandom_range(WORDS - 1));
      len = int'($urandom_range(12, 1));
      issue_cmd(OP_FILL, 0, src, len, $urandom, 4'(m));
      issue_cmd(OP_SUM, src + WORDS - 2, 0, len + 4, 32'd0, 4'hF);  // Neighbours included
    end
    // Copies longer than the buffer, first one wraps
    for (int k = 0; k < 8; k++) begin
      len = (k == 0) ? RUNLEN : int'($urandom_range(RUNLEN, 1));
      src = (k == 0) ? WORDS - 5 : int'($urandom_range(WORDS - 1));
      dst = src + len + int'($urandom_range(WORDS - 2 * len));  // Runs never overlap
      issue_cmd(OP_FILL, 0, src, len / 2, $urandom, 4'hF);
      issue_cmd(OP_FILL, 0, src + len / 2, len - len / 2, $urandom, 4'hF);
      issue_cmd(OP_COPY, src, dst, len, 32'd0, 4'hF);
      issue_cmd(OP_SUM, src, 0, len, 32'd0, 4'hF);
      issue_cmd(OP_SUM, dst, 0, len, 32'd0, 4'hF);
    end
    // Zero length for each opcode
    issue_cmd(OP_FILL, 9, 17, 0, 32'hFFFF_FFFF, 4'hF);
    issue_cmd(OP_COPY, 30, 90, 0, 32'd0, 4'hF);
    issue_cmd(OP_SUM, 5, 0, 0, 32'd0, 4'hF);
    bp_pct = 50;
    for (int n = 0; n < 200; n++) begin
      op  = wb_op_e'(2'($urandom_range(2)));
      len = int'($urandom_range(RUNLEN));
      src = int'($urandom_range(WORDS - 1));
      dst = (op == OP_COPY) ? src + len + int'($urandom_range(WORDS - 2 * len))
                            : int'($urandom_range(WORDS - 1));
      issue_cmd(op, src, dst, len, $urandom, 4'($urandom_range(15, 1)));
    end
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    if (pending == 0 && checked == issued) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      abort_run($sformatf("Run ended with %0d of %0d results missing", issued - checked, issued));
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wb_bus_master.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wb_mem_config.svh"

module wb_bus_master (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       req_valid_i,
  input  wire wb_mem_pkg::bus_req_t req_i,
  output logic                      req_ready_o,
  output logic                      rd_valid_o,   // Read word returned
  output logic [31:0]               rd_data_o,
  output logic                      wr_ack_o,     // Write acknowledged
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic                      wb_we_o,
  output logic [`WB_ADDR_W-1:0]     wb_adr_o,
  output logic [31:0]               wb_dat_o,
  output logic [3:0]                wb_sel_o,
  input  wire [31:0]                wb_dat_i,
  input  wire                       wb_ack_i,
  input  wire                       wb_stall_i
);

  // Controller bounds reads and writes separately, so twice the buffer depth covers both
  localparam int QD = 2 * `WB_FIFO_DEPTH;
  localparam int PW = $clog2(QD);

  logic [QD-1:0] we_q;      // we flag per outstanding transfer
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   cnt;       // Outstanding transfers
  logic          issue;     // Transfer accepted by the slave
  logic          ack_we;    // Kind of the transfer being acked

  // Request maps straight onto the bus
  assign wb_stb_o = req_valid_i;
  assign wb_we_o  = req_i.we;
  assign wb_adr_o = req_i.adr;
  assign wb_dat_o = req_i.dat;
  assign wb_sel_o = req_i.sel;

  assign wb_cyc_o    = req_valid_i | (cnt != '0);  // Open until the last ack
  assign req_ready_o = ~wb_stall_i;
  assign issue       = req_valid_i & ~wb_stall_i;

  // An ack with nothing queued belongs to the transfer issuing right now
  assign ack_we = (cnt == '0) ? req_i.we : we_q[rd_ptr];

  assign rd_valid_o = wb_ack_i & ~ack_we;
  assign rd_data_o  = wb_dat_i;
  assign wr_ack_o   = wb_ack_i & ack_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (issue) wr_ptr <= wr_ptr + 1'b1;
      if (wb_ack_i) rd_ptr <= rd_ptr + 1'b1;
      case ({issue, wb_ack_i})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) we_q[wr_ptr] <= req_i.we;
  end

  // Slave only acks what was issued, now or earlier
  ack_outstanding_a: assert property (@(posedge clk) disable iff (rst)
    wb_ack_i |-> (cnt != '0 || issue));

  outstanding_bound_a: assert property (@(posedge clk) disable iff (rst)
    cnt <= (PW+1)'(QD));

endmodule

`default_nettype wire

// ==== verilog/wb_copy_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wb_mem_config.svh"

module wb_copy_ctrl (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              cmd_valid_i,
  input  wire wb_mem_pkg::cmd_t            cmd_i,
  output logic                             cmd_ready_o,
  output logic                             rsp_valid_o,
  output wb_mem_pkg::rsp_t                 rsp_o,
  input  wire                              rsp_ready_i,
  output logic                             req_valid_o,
  output wb_mem_pkg::bus_req_t             req_o,
  input  wire                              req_ready_i,
  input  wire                              rd_valid_i,
  input  wire [31:0]                       rd_data_i,
  input  wire                              wr_ack_i,
  output logic                             fifo_pop_o,
  input  wire [31:0]                       fifo_data_i,
  input  wire [$clog2(`WB_FIFO_DEPTH):0]   fifo_count_i
);

  import wb_mem_pkg::*;

  localparam int AW = `WB_ADDR_W;
  localparam int LW = `WB_LEN_W;
  localparam int FD = `WB_FIFO_DEPTH;

  ctrl_state_e   state_q, state_d;
  cmd_t          cmd_q;                  // Latched command
  logic [LW-1:0] rd_issued, rd_done;     // Read requests sent and returned
  logic [LW-1:0] wr_issued, wr_done;
  logic [LW-1:0] rd_target, wr_target;   // Per-op transfer counts
  logic [LW-1:0] rd_out, wr_out;         // In flight
  logic [31:0]   acc_q;                  // SUM accumulator
  logic          ready_q;
  logic          hold_q, hold_wr_q;      // Stalled request and its kind
  logic          can_rd, can_wr, pick_wr;
  logic          req_fire, issue_done, all_done;

  assign rd_target = (cmd_q.op == OP_FILL) ? '0 : cmd_q.len;
  assign wr_target = (cmd_q.op == OP_SUM) ? '0 : cmd_q.len;
  assign rd_out    = rd_issued - rd_done;
  assign wr_out    = wr_issued - wr_done;

  // Reads in flight plus buffered words never exceed the buffer
  assign can_rd = (state_q == RUN) && (rd_issued != rd_target) &&
                  (int'(rd_out) + int'(fifo_count_i) < FD);
  // COPY writes need a buffered word
  assign can_wr = (state_q == RUN) && (wr_issued != wr_target) && (int'(wr_out) < FD) &&
                  ((cmd_q.op != OP_COPY) || (fifo_count_i != '0));

  assign pick_wr     = hold_q ? hold_wr_q : can_wr;  // Writes win, keeps the FIFO shallow
  assign req_valid_o = hold_q | can_rd | can_wr;
  assign req_fire    = req_valid_o & req_ready_i;
  assign fifo_pop_o  = req_fire & pick_wr & (cmd_q.op == OP_COPY);

  always_comb begin
    req_o     = '0;
    req_o.we  = pick_wr;
    // FILL writes at dst_addr, SUM reads at src_addr; addresses wrap with the RAM
    req_o.adr = pick_wr ? cmd_q.dst_addr + AW'(wr_issued) : cmd_q.src_addr + AW'(rd_issued);
    req_o.dat = (cmd_q.op == OP_COPY) ? fifo_data_i : cmd_q.pattern;
    req_o.sel = (cmd_q.op == OP_FILL) ? cmd_q.sel : 4'hF;
  end

  assign issue_done = (rd_issued == rd_target) && (wr_issued == wr_target);
  assign all_done   = (rd_done == rd_target) && (wr_done == wr_target);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (cmd_valid_i && cmd_ready_o) state_d = RUN;
      RUN:     if (issue_done) state_d = all_done ? RESP : DRAIN;  // Zero length goes straight on
      DRAIN:   if (all_done) state_d = RESP;
      RESP:    if (rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign cmd_ready_o = ready_q;  // Low for the first clock out of reset
  assign rsp_valid_o = (state_q == RESP);
  assign rsp_o.op    = cmd_q.op;
  assign rsp_o.value = (cmd_q.op == OP_SUM) ? acc_q : 32'd0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      ready_q   <= 1'b0;
      hold_q    <= 1'b0;
      hold_wr_q <= 1'b0;
      rd_issued <= '0;
      rd_done   <= '0;
      wr_issued <= '0;
      wr_done   <= '0;
      acc_q     <= '0;
    end else begin
      state_q   <= state_d;
      ready_q   <= (state_d == IDLE);
      hold_q    <= req_valid_o & ~req_ready_i;  // Bus stalled us
      hold_wr_q <= pick_wr;
      if (cmd_valid_i && cmd_ready_o) begin
        rd_issued <= '0;
        rd_done   <= '0;
        wr_issued <= '0;
        wr_done   <= '0;
        acc_q     <= '0;
      end else begin
        if (req_fire && !pick_wr) rd_issued <= rd_issued + 1'b1;
        if (req_fire && pick_wr) wr_issued <= wr_issued + 1'b1;
        if (rd_valid_i) rd_done <= rd_done + 1'b1;
        if (wr_ack_i) wr_done <= wr_done + 1'b1;
        if (rd_valid_i && cmd_q.op == OP_SUM) acc_q <= acc_q + rd_data_i;  // Wrapping add
      end
    end
  end

  // Command payload
  always_ff @(posedge clk) begin
    if (cmd_valid_i && cmd_ready_o) cmd_q <= cmd_i;
  end

  // Result held steady until taken
  rsp_stable_a: assert property (@(posedge clk) disable iff (rst)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)));

endmodule

`default_nettype wire

// ==== verilog/wb_copy_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wb_mem_config.svh"

// First word fall through buffer between COPY reads and writes
module wb_copy_fifo (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              push_i,
  input  wire [31:0]                       push_data_i,
  input  wire                              pop_i,
  output logic [31:0]                      pop_data_o,  // Head word, valid when count is nonzero
  output logic [$clog2(`WB_FIFO_DEPTH):0]  count_o
);

  localparam int D  = `WB_FIFO_DEPTH;
  localparam int PW = $clog2(D);

  logic [31:0]   mem [D];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;

  assign pop_data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (pop_i) rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) mem[wr_ptr] <= push_data_i;
  end

  // Controller read throttling keeps us from overflowing
  no_push_full_a: assert property (@(posedge clk) disable iff (rst)
    push_i |-> (count_o < (PW+1)'(D)));

  no_pop_empty_a: assert property (@(posedge clk) disable iff (rst)
    pop_i |-> (count_o != '0));

endmodule

`default_nettype wire

// ==== verilog/wb_copy_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wb_mem_config.svh"

module wb_copy_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   cmd_valid_i,
  input  wire wb_mem_pkg::cmd_t cmd_i,
  output logic                  cmd_ready_o,
  output logic                  rsp_valid_o,
  output wb_mem_pkg::rsp_t      rsp_o,
  input  wire                   rsp_ready_i
);

  import wb_mem_pkg::*;

  bus_req_t                         req;
  logic                             req_valid, req_ready;
  logic                             rd_valid, wr_ack;
  logic [31:0]                      rd_data;
  logic                             fifo_push, fifo_pop;
  logic [31:0]                      fifo_data;
  logic [$clog2(`WB_FIFO_DEPTH):0]  fifo_count;
  logic                             wb_cyc, wb_stb, wb_we, wb_ack, wb_stall;
  logic [`WB_ADDR_W-1:0]            wb_adr;
  logic [31:0]                      wb_dat_w, wb_dat_r;
  logic [3:0]                       wb_sel;

  // rsp_o.op follows the latched command, so only COPY reads land in the buffer
  assign fifo_push = rd_valid & (rsp_o.op == OP_COPY);

  wb_copy_ctrl wb_copy_ctrl_i (
    .clk, .rst, .cmd_valid_i, .cmd_i, .cmd_ready_o, .rsp_valid_o, .rsp_o, .rsp_ready_i,
    .req_valid_o(req_valid), .req_o(req), .req_ready_i(req_ready),
    .rd_valid_i(rd_valid), .rd_data_i(rd_data), .wr_ack_i(wr_ack),
    .fifo_pop_o(fifo_pop), .fifo_data_i(fifo_data), .fifo_count_i(fifo_count)
  );

  wb_bus_master wb_bus_master_i (
    .clk, .rst, .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
    .rd_valid_o(rd_valid), .rd_data_o(rd_data), .wr_ack_o(wr_ack),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack),
    .wb_stall_i(wb_stall)
  );

  wb_copy_fifo wb_copy_fifo_i (
    .clk, .rst, .push_i(fifo_push), .push_data_i(rd_data), .pop_i(fifo_pop),
    .pop_data_o(fifo_data), .count_o(fifo_count)
  );

  wb_ram wb_ram_i (
    .clk, .rst, .adr_i(wb_adr), .dat_i(wb_dat_w), .we_i(wb_we), .sel_i(wb_sel),
    .stb_i(wb_stb), .cyc_i(wb_cyc), .dat_o(wb_dat_r), .ack_o(wb_ack), .stall_o(wb_stall)
  );

endmodule

`default_nettype wire

// ==== verilog/wb_mem_pkg.sv ====
`default_nettype none
`include "wb_mem_config.svh"

package wb_mem_pkg;

  // Command opcodes
  typedef enum logic [1:0] {
    OP_FILL = 2'd0,  // Pattern write over a run
    OP_COPY = 2'd1,  // Run to run copy
    OP_SUM  = 2'd2   // Wrapping sum of a run
  } wb_op_e;

  // Controller FSM states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // Waiting for a command
    RUN   = 2'd1,  // Issuing bus requests
    DRAIN = 2'd2,  // All issued, waiting for acks
    RESP  = 2'd3   // Result offered
  } ctrl_state_e;

  // One command as seen on the command port
  typedef struct packed {
    wb_op_e                 op;
    logic [`WB_ADDR_W-1:0]  src_addr;  // Read start, COPY and SUM
    logic [`WB_ADDR_W-1:0]  dst_addr;  // Write start, COPY and FILL
    logic [`WB_LEN_W-1:0]   len;       // Word count, zero is legal
    logic [31:0]            pattern;   // FILL data
    logic [3:0]             sel;       // FILL byte mask
  } cmd_t;

  // One result
  typedef struct packed {
    wb_op_e      op;
    logic [31:0] value;  // Sum for OP_SUM, else zero
  } rsp_t;

  // One Wishbone transfer request from controller to master
  typedef struct packed {
    logic                  we;
    logic [`WB_ADDR_W-1:0] adr;
    logic [31:0]           dat;
    logic [3:0]            sel;
  } bus_req_t;

endpackage

`default_nettype wire

// ==== verilog/wb_ram.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wb_mem_config.svh"

// Classic single cycle slave behind a pipelined master interface
module wb_ram (
  input  wire                   clk,
  input  wire                   rst,
  input  wire [`WB_ADDR_W-1:0]  adr_i,   // Word address
  input  wire [31:0]            dat_i,   // Write data
  input  wire                   we_i,
  input  wire [3:0]             sel_i,   // Byte selects
  input  wire                   stb_i,
  input  wire                   cyc_i,
  output logic [31:0]           dat_o,   // Read data, valid with ack
  output logic                  ack_o,
  output logic                  stall_o
);

  localparam int AW = `WB_ADDR_W;

  logic [31:0] mem [1<<AW];  // Word array, no init
  logic        take;         // Slave sees a new strobe this cycle
  logic [31:0] wr_word;      // Addressed word after byte merge

  // Strobe is taken while no ack is up; the held strobe in the ack cycle is the same transfer
  assign take = cyc_i & stb_i & ~ack_o;

  // Master keeps stb held until our ack comes back
  assign stall_o = cyc_i & ~ack_o;

  always_comb begin
    wr_word = mem[adr_i];
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) wr_word[8*b +: 8] = dat_i[8*b +: 8];  // Selected lanes only
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= take;  // One clock after the strobe is taken
    end
  end

  // Array and read register
  always_ff @(posedge clk) begin
    if (take) begin
      if (we_i) mem[adr_i] <= wr_word;
      dat_o <= wr_word;  // Write first on a collision
    end
  end

  // A stalled strobe is still there, unchanged, when our ack pairs with it
  stb_held_a: assert property (@(posedge clk) disable iff (rst)
    (cyc_i && stb_i && stall_o) |=>
      (stb_i && $stable(adr_i) && $stable(we_i) && $stable(sel_i)));

  // A write with an empty mask is a bus master bug
  write_sel_a: assert property (@(posedge clk) disable iff (rst)
    (take && we_i) |-> (sel_i != 4'b0000));

endmodule

`default_nettype wire

// ==== wb_copy_top.f ====
+incdir+include
verilog/wb_mem_pkg.sv
verilog/wb_ram.sv
verilog/wb_bus_master.sv
verilog/wb_copy_fifo.sv
verilog/wb_copy_ctrl.sv
verilog/wb_copy_top.sv
verif/tb_clk_gen.sv
verif/wb_copy_tb.sv
